// ==== game_pkg.sv ====
package game_pkg;

    // Game controller states
    typedef enum logic [1:0] {
        MENU,
        PLAY,
        SCORE
    } game_state_t;

    // Controller outputs, start is a one-cycle pulse
    typedef struct packed {
        logic menu;
        logic playing;
        logic start;
        logic show_score;
    } game_ctrl_t;

    // Per-lane result at the hit line
    typedef struct packed {
        logic active;
        logic hit;
        logic miss;
    } lane_status_t;

    // Song position, advance pulses once per step
    typedef struct packed {
        logic [4:0] step;
        logic       advance;
    } song_pos_t;

    localparam int NUM_LANES = 8;
    localparam int MAX_STEPS = 32;

    // One lane's chart at full length
    typedef logic [MAX_STEPS-1:0] chart_t;

    // Keyboard codes
    localparam logic [7:0] KEY_START = 8'h28;
    localparam logic [7:0] KEY_MENU  = 8'h29;

    // Lane keys A S D F J K L ; with lane 0 in the low byte
    localparam logic [NUM_LANES-1:0][7:0] LANE_KEYS = {
        8'h33, 8'h0f, 8'h0e, 8'h0d, 8'h09, 8'h07, 8'h16, 8'h04
    };

endpackage

// ==== display_pkg.sv ====
package display_pkg;

    // Active low, segment a in bit 0
    typedef logic [6:0] hex_digit_t;

    // Digit 0 in the low bits
    typedef hex_digit_t [7:0] hex_bank_t;

    // Hex value to segment pattern
    function automatic hex_digit_t hex_font(input logic [3:0] value);
        case (value)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'ha: return 7'b0001000;
            4'hb: return 7'b0000011;
            4'hc: return 7'b1000110;
            4'hd: return 7'b0100001;
            4'he: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

endpackage

// ==== game_control.sv ====
module game_control (
    input  logic                 Clk,
    input  logic                 reset,
    input  logic [7:0]           key,
    input  logic                 song_over,
    output game_pkg::game_ctrl_t ctrl
);
    import game_pkg::*;

    game_state_t state;
    game_state_t state_next;
    logic        start_q;
    logic        start_key;
    logic        menu_key;

    // Key decode
    assign start_key = (key == KEY_START);
    assign menu_key  = (key == KEY_MENU);

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            MENU: begin
                if (start_key) begin
                    state_next = PLAY;
                end
            end
            PLAY: begin
                // Song clock ends the round
                if (song_over) begin
                    state_next = SCORE;
                end
            end
            SCORE: begin
                if (menu_key) begin
                    state_next = MENU;
                end
            end
            default: state_next = MENU;
        endcase
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            state   <= MENU;
            start_q <= 1'b0;
        end else begin
            state   <= state_next;
            // High for the first PLAY cycle only
            start_q <= (state == MENU) && start_key;
        end
    end

    // Level flags straight from the state
    always_comb begin
        ctrl.menu       = (state == MENU);
        ctrl.playing    = (state == PLAY);
        ctrl.start      = start_q;
        ctrl.show_score = (state == SCORE);
    end

endmodule

// ==== song_clock.sv ====
module song_clock #(
    parameter int CHART_LEN   = 16,
    parameter int STEP_FRAMES = 4
) (
    input  logic                 Clk,
    input  logic                 reset,
    input  logic                 frame_tick,
    input  game_pkg::game_ctrl_t ctrl,
    output game_pkg::song_pos_t  pos,
    output logic                 song_over
);
    // Frame counter wide enough for one step
    localparam int                 FRAME_W    = (STEP_FRAMES > 1) ? $clog2(STEP_FRAMES) : 1;
    localparam logic [FRAME_W-1:0] LAST_FRAME = FRAME_W'(STEP_FRAMES - 1);
    localparam logic [4:0]         LAST_STEP  = 5'(CHART_LEN - 1);

    logic [FRAME_W-1:0] frame_cnt;
    logic [4:0]         step;
    logic               advance;
    logic               ended;
    logic               counting;
    logic               step_due;

    // Ticks only count during a running song
    assign counting = ctrl.playing && !ended && frame_tick;
    assign step_due = counting && (frame_cnt == LAST_FRAME);

    always_ff @(posedge Clk) begin
        // Menu keeps the counters at zero so a new song opens on step 0
        if (reset || ctrl.menu || ctrl.start) begin
            frame_cnt <= '0;
            step      <= '0;
            advance   <= 1'b0;
            ended     <= 1'b0;
            song_over <= 1'b0;
        end else begin
            advance   <= step_due;
            song_over <= step_due && (step == LAST_STEP);
            if (counting) begin
                frame_cnt <= step_due ? '0 : frame_cnt + FRAME_W'(1);
            end
            if (step_due) begin
                // Last step ends the song, step stays put
                if (step == LAST_STEP) begin
                    ended <= 1'b1;
                end else begin
                    step <= step + 5'd1;
                end
            end
        end
    end

    assign pos.step    = step;
    assign pos.advance = advance;

endmodule

// ==== note_lane.sv ====
module note_lane #(
    parameter int                   LANE      = 0,
    parameter int                   CHART_LEN = 16,
    parameter logic [CHART_LEN-1:0] CHART     = '0
) (
    input  logic                   Clk,
    input  logic                   reset,
    input  logic [7:0]             key,
    input  game_pkg::game_ctrl_t   ctrl,
    input  game_pkg::song_pos_t    pos,
    output game_pkg::lane_status_t status
);
    import game_pkg::*;

    chart_t chart;
    logic   key_match;
    logic   active;
    logic   hit;
    logic   miss;
    logic   note_q;

    // Zero-extended so any 5-bit step is in range
    assign chart = chart_t'(CHART);

    // This lane's key held
    assign key_match = (key == LANE_KEYS[LANE]);

    // Note at the hit line
    assign active = ctrl.playing && chart[pos.step];

    always_ff @(posedge Clk) begin
        if (reset) begin
            hit    <= 1'b0;
            miss   <= 1'b0;
            note_q <= 1'b0;
        end else begin
            // Step has already moved when advance is high
            // so the old note comes from the delayed flag
            note_q <= active;
            miss   <= pos.advance && note_q && !hit;

            // Hit lasts for the life of the note
            if (pos.advance || !ctrl.playing) begin
                hit <= 1'b0;
            end else if (active && key_match) begin
                hit <= 1'b1;
            end
        end
    end

    assign status.active = active;
    assign status.hit    = hit;
    assign status.miss   = miss;

endmodule

// ==== score_keeper.sv ====
module score_keeper (
    input  logic                                            Clk,
    input  logic                                            reset,
    input  game_pkg::game_ctrl_t                            ctrl,
    input  game_pkg::lane_status_t [game_pkg::NUM_LANES-1:0] lanes,
    output logic [11:0]                                     score
);
    import game_pkg::*;

    // Enough bits to count every lane at once
    localparam int CNT_W = $clog2(NUM_LANES + 1);

    logic [NUM_LANES-1:0] hit_now;
    logic [NUM_LANES-1:0] hit_q;
    logic [NUM_LANES-1:0] fell;
    logic [CNT_W-1:0]     fell_cnt;

    // Gather hit flags
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            hit_now[i] = lanes[i].hit;
        end
    end

    // One point per falling edge of a hit flag
    assign fell = hit_q & ~hit_now;

    // Falls this cycle
    always_comb begin
        fell_cnt = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            fell_cnt = fell_cnt + CNT_W'(fell[i]);
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            hit_q <= '0;
            score <= '0;
        end else begin
            hit_q <= hit_now;
            // New round starts from zero
            if (ctrl.menu || ctrl.start) begin
                score <= '0;
            end else begin
                // Lanes are idle in SCORE, so only the last step's
                // hits still land and the total then holds
                score <= score + 12'(fell_cnt);
            end
        end
    end

endmodule

// ==== hex_display.sv ====
module hex_display (
    input  logic                   Clk,
    input  logic                   reset,
    input  logic [11:0]            score,
    input  game_pkg::game_ctrl_t   ctrl,
    input  game_pkg::song_pos_t    pos,
    output display_pkg::hex_bank_t hex
);
    import display_pkg::*;

    hex_bank_t hex_next;
    logic      song_done;

    // Neither menu nor playing means the song is over
    assign song_done = !ctrl.menu && !ctrl.playing;

    // Digit layout
    always_comb begin
        // Score, three hex digits
        hex_next[0] = hex_font(score[3:0]);
        hex_next[1] = hex_font(score[7:4]);
        hex_next[2] = hex_font(score[11:8]);
        // Blank column shows zero
        hex_next[3] = hex_font(4'h0);
        // Status flags
        hex_next[4] = hex_font({3'b000, song_done});
        hex_next[5] = hex_font({3'b000, ctrl.show_score});
        // Song step
        hex_next[6] = hex_font(pos.step[3:0]);
        hex_next[7] = hex_font({3'b000, pos.step[4]});
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            hex <= {8{hex_font(4'h0)}};
        end else begin
            hex <= hex_next;
        end
    end

endmodule

// ==== rhythm_game_top.sv ====
module rhythm_game_top #(
    parameter int                                      CHART_LEN   = 16,
    parameter int                                      STEP_FRAMES = 4,
    parameter logic [game_pkg::NUM_LANES*CHART_LEN-1:0] CHARTS      =
        128'h8421_1248_4444_2222_0f0f_f0f0_3c3c_c3c3
) (
    input  logic                           Clk,
    input  logic                           reset,
    input  logic                           frame_tick,
    input  logic [7:0]                     key,
    input  logic [15:0]                    audio_in,
    output display_pkg::hex_bank_t         hex,
    output logic [game_pkg::NUM_LANES-1:0] lane_active,
    output logic [game_pkg::NUM_LANES-1:0] lane_hit,
    output logic                           warning,
    output logic [15:0]                    audio_out
);
    import game_pkg::*;

    game_ctrl_t                   ctrl;
    song_pos_t                    pos;
    logic                         song_over;
    lane_status_t [NUM_LANES-1:0] lanes;
    logic [NUM_LANES-1:0]         lane_miss;
    logic [11:0]                  score;

    // Menu, play, score
    game_control game_control_i (
        .Clk       (Clk),
        .reset     (reset),
        .key       (key),
        .song_over (song_over),
        .ctrl      (ctrl)
    );

    // Shared song clock
    song_clock #(
        .CHART_LEN   (CHART_LEN),
        .STEP_FRAMES (STEP_FRAMES)
    ) song_clock_i (
        .Clk        (Clk),
        .reset      (reset),
        .frame_tick (frame_tick),
        .ctrl       (ctrl),
        .pos        (pos),
        .song_over  (song_over)
    );

    // One lane per key, each with its own slice of the chart
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        note_lane #(
            .LANE      (l),
            .CHART_LEN (CHART_LEN),
            .CHART     (CHARTS[l*CHART_LEN +: CHART_LEN])
        ) note_lane_i (
            .Clk    (Clk),
            .reset  (reset),
            .key    (key),
            .ctrl   (ctrl),
            .pos    (pos),
            .status (lanes[l])
        );

        assign lane_active[l] = lanes[l].active;
        assign lane_hit[l]    = lanes[l].hit;
        assign lane_miss[l]   = lanes[l].miss;
    end

    // Any lane missing
    assign warning = |lane_miss;

    score_keeper score_keeper_i (
        .Clk   (Clk),
        .reset (reset),
        .ctrl  (ctrl),
        .lanes (lanes),
        .score (score)
    );

    hex_display hex_display_i (
        .Clk   (Clk),
        .reset (reset),
        .score (score),
        .ctrl  (ctrl),
        .pos   (pos),
        .hex   (hex)
    );

    // Sound only while playing
    assign audio_out = ctrl.playing ? audio_in : 16'h0000;

endmodule

// ==== tb_rhythm_game.sv ====
module tb_rhythm_game;

    // Lane 0 in the low 16 bits
    // At most three notes in any step
    localparam logic [127:0] TB_CHARTS = 128'h00a0_5000_0c30_0303_8888_4444_2222_1111;
    localparam int           STEPS     = 16;

    // Active-low patterns for F down to 0
    // Segment a in bit 0
    localparam logic [15:0][6:0] FONT = {
        7'b0001110, 7'b0000110, 7'b0100001, 7'b1000110,
        7'b0000011, 7'b0001000, 7'b0010000, 7'b0000000,
        7'b1111000, 7'b0000010, 7'b0010010, 7'b0011001,
        7'b0110000, 7'b0100100, 7'b1111001, 7'b1000000
    };

    // Lane keys A S D F J K L ; with lane 0 lowest
    localparam logic [7:0][7:0] LANE_CODES = {
        8'h33, 8'h0f, 8'h0e, 8'h0d, 8'h09, 8'h07, 8'h16, 8'h04
    };
    localparam logic [7:0] START_CODE = 8'h28;
    localparam logic [7:0] MENU_CODE  = 8'h29;

    logic            Clk;
    logic            reset;
    logic            frame_tick;
    logic [7:0]      key;
    logic [15:0]     audio_in;
    logic [7:0][6:0] hex_out;
    logic [7:0]      lane_active;
    logic [7:0]      lane_hit;
    logic            warning;
    logic [15:0]     audio_out;

    int seed          = 32'hba14;
    int tick_div      = 0;
    int error_count   = 0;
    int check_count   = 0;
    int warn_seen     = 0;
    int warn_expected = 0;
    int hits_expected = 0;

    rhythm_game_top #(
        .CHART_LEN   (16),
        .STEP_FRAMES (2),
        .CHARTS      (TB_CHARTS)
    ) rhythm_game_top_i (
        .Clk         (Clk),
        .reset       (reset),
        .frame_tick  (frame_tick),
        .key         (key),
        .audio_in    (audio_in),
        .hex         (hex_out),
        .lane_active (lane_active),
        .lane_hit    (lane_hit),
        .warning     (warning),
        .audio_out   (audio_out)
    );

    initial begin
        Clk = 1'b0;
        forever begin
            #50 Clk = ~Clk;
        end
    end

    // Frame strobe on every fourth cycle
    initial begin
        frame_tick = 1'b0;
        forever begin
            @(posedge Clk);
            tick_div = (tick_div + 1) % 4;
            frame_tick <= (tick_div == 0);
        end
    end

    // Warning pulses seen over the whole song
    always @(negedge Clk) begin
        if (warning === 1'b1) begin
            warn_seen++;
        end
    end

    task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        check_count++;
        assert (got === exp) else begin
            $display("FAIL at time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
            error_count++;
        end
    endtask

    // Pattern of one digit in its slot of the bank
    function automatic logic [55:0] place_digit(input int idx, input int value);
        logic [55:0] bank;
        bank = '0;
        bank[idx*7 +: 7] = FONT[value[3:0]];
        return bank;
    endfunction

    function automatic logic [55:0] digit_mask(input int first, input int last);
        logic [55:0] mask;
        mask = '0;
        for (int d = first; d <= last; d++) begin
            mask[d*7 +: 7] = 7'h7f;
        end
        return mask;
    endfunction

    function automatic logic [55:0] uniform_digits(input int value);
        logic [55:0] bank;
        bank = '0;
        for (int d = 0; d < 8; d++) begin
            bank |= place_digit(d, value);
        end
        return bank;
    endfunction

    // Score in three hex digits
    function automatic logic [55:0] score_digits(input int value);
        return place_digit(0, value) | place_digit(1, value >> 4) | place_digit(2, value >> 8);
    endfunction

    function automatic logic [7:0] notes_at(input int step);
        logic [7:0] mask;
        for (int l = 0; l < 8; l++) begin
            mask[l] = TB_CHARTS[l*16 + step];
        end
        return mask;
    endfunction

    task automatic wait_digits(input logic [55:0] mask, input logic [55:0] value,
                               input int limit, input string what);
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < limit && !seen; i++) begin
            @(negedge Clk);
            seen = ((hex_out & mask) === value);
        end
        if (!seen) begin
            $display("Timeout: %s not shown on the display after %0d cycles", what, limit);
            error_count++;
        end
    endtask

    task automatic idle_after_reset();
        @(negedge Clk);
        check_equal(64'(hex_out), 64'(uniform_digits(0)), "hex digits after reset");
        check_equal(64'(lane_active), 64'(0), "lane_active after reset");
        check_equal(64'(lane_hit), 64'(0), "lane_hit after reset");
        check_equal(64'(warning), 64'(0), "warning after reset");
        check_equal(64'(audio_out), 64'(0), "audio muted in menu");
    endtask

    task automatic start_game();
        @(posedge Clk);
        key <= START_CODE;
        @(posedge Clk);
        key <= 8'h00;
        // Play begins on the edge after the start key
        // Step 0 is at the hit line from the first play cycle
        @(negedge Clk);
        check_equal(64'(audio_out), 64'(audio_in), "audio passes while playing");
        check_equal(64'(lane_active), 64'(notes_at(0)), "lanes active at step 0");
    endtask

    task automatic play_step(input int step);
        logic [7:0] active;
        logic [7:0] chosen;
        int         probe;
        active = notes_at(step);
        chosen = '0;
        for (int l = 0; l < 8; l++) begin
            if (active[l] && ($random(seed) & 1) == 1) begin
                chosen[l] = 1'b1;
            end
        end
        // Some lane without a note
        probe = $unsigned($random(seed)) % 8;
        while (active[probe]) begin
            probe = (probe + 1) % 8;
        end
        @(posedge Clk);
        key <= LANE_CODES[probe];
        // One key per cycle
        for (int l = 0; l < 8; l++) begin
            if (chosen[l]) begin
                @(posedge Clk);
                key <= LANE_CODES[l];
            end
        end
        @(posedge Clk);
        key      <= 8'h00;
        audio_in <= 16'($random(seed));
        @(negedge Clk);
        check_equal(64'(lane_hit), 64'(chosen), $sformatf("lane hits at step %0d", step));
        check_equal(64'(audio_out), 64'(audio_in), "audio follows input");
        hits_expected += $countones(chosen);
        // Misses of one step share a single pulse
        if ((active & ~chosen) != 8'h00) begin
            warn_expected++;
        end
    endtask

    task automatic play_song();
        for (int s = 0; s < STEPS; s++) begin
            if (s > 0) begin
                wait_digits(digit_mask(6, 7), place_digit(6, s) | place_digit(7, s >> 4),
                            20, $sformatf("step %0d", s));
                check_equal(64'(lane_active), 64'(notes_at(s)),
                            $sformatf("lanes active at step %0d", s));
            end
            play_step(s);
        end
    endtask

    task automatic score_after_song();
        wait_digits(digit_mask(5, 5), place_digit(5, 1), 20, "show-score flag");
        check_equal(64'(hex_out & digit_mask(4, 5)), 64'(place_digit(4, 1) | place_digit(5, 1)),
                    "song-over and show-score digits");
        // Last step's hits reach the score one cycle after the flags
        @(negedge Clk);
        check_equal(64'(hex_out & digit_mask(0, 2)), 64'(score_digits(hits_expected)),
                    "score digits");
        check_equal(64'(warn_seen), 64'(warn_expected), "warning pulse count");
    endtask

    task automatic return_to_menu();
        @(posedge Clk);
        key <= MENU_CODE;
        @(posedge Clk);
        key <= 8'h00;
        wait_digits(digit_mask(5, 5), place_digit(5, 0), 10, "menu flags");
        // Score clears one cycle after the flags drop
        @(negedge Clk);
        check_equal(64'(hex_out & digit_mask(0, 5)), 64'(uniform_digits(0) & digit_mask(0, 5)),
                    "score and flag digits in menu");
        check_equal(64'(audio_out), 64'(0), "audio muted after menu key");
        check_equal(64'(lane_active), 64'(0), "lanes idle in menu");
    endtask

    initial begin
        reset    = 1'b1;
        key      = 8'h00;
        audio_in = 16'h5a3c;
        repeat (2) @(posedge Clk);
        reset <= 1'b0;
        idle_after_reset();
        start_game();
        play_song();
        score_after_song();
        return_to_menu();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
game_pkg.sv
display_pkg.sv
game_control.sv
song_clock.sv
note_lane.sv
score_keeper.sv
hex_display.sv
rhythm_game_top.sv
tb_rhythm_game.sv

// ==== Makefile ====
TOP = tb_rhythm_game

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module $(TOP) -f sources.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
